//--- apb_csr_block.sv
/* APB register block with one stored parity bit per word.
   Inserts WAIT_STATES access cycles before pready; out-of-range words error. */

`timescale 1ns/10ps

module apb_csr_block #(
  parameter int REGS_PER_BLOCK = 16,
  parameter int WAIT_STATES    = 0
) (
  input  logic                   prim_gated_clk,
  input  logic                   prim_gated_rst_b,
  input  logic                   sel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [31:0]            paddr,
  input  logic [31:0]            pwdata,
  input  cfg_apb_pkg::apb_user_t puser,
  output logic                   pready,
  output logic                   pslverr,
  output logic [31:0]            prdata,
  output logic                   prdata_par
);

  localparam int IDX_W  = (REGS_PER_BLOCK > 1) ? $clog2(REGS_PER_BLOCK) : 1;
  localparam int WAIT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [31:0]               regs_q [REGS_PER_BLOCK];
  logic [REGS_PER_BLOCK-1:0] par_q;
  logic [25:0]               word_idx;
  logic [IDX_W-1:0]          idx;
  logic                      in_range;
  logic                      access;
  logic [WAIT_W-1:0]         wait_cnt_q;
  logic                      wait_done;
  logic                      wr_en;

  // Word index inside the 256 MB region
  assign word_idx = paddr[27:2];
  assign idx      = word_idx[IDX_W-1:0];
  assign in_range = (word_idx < 26'(REGS_PER_BLOCK));

  assign access    = sel & penable;
  assign wait_done = (wait_cnt_q == WAIT_W'(WAIT_STATES));

  // --------------------
  // Wait states

  always_ff @(posedge prim_gated_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      wait_cnt_q <= '0;
    end else if (!access || wait_done) begin
      wait_cnt_q <= '0;
    end else begin
      wait_cnt_q <= wait_cnt_q + 1'b1;
    end
  end

  assign pready  = access & wait_done;
  assign pslverr = pready & ~in_range;
  assign wr_en   = pready & pwrite & in_range;

  // --------------------
  // Register file

  // Write parity is stored as sent, so a bad one shows on a later read
  always_ff @(posedge prim_gated_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      for (int i = 0; i < REGS_PER_BLOCK; i++) begin
        regs_q[i] <= '0;
      end
      par_q <= '0;
    end else if (wr_en) begin
      regs_q[idx] <= pwdata;
      par_q[idx]  <= puser.wd_par;
    end
  end

  assign prdata     = in_range ? regs_q[idx] : '0;
  assign prdata_par = in_range & par_q[idx];

endmodule

//--- apb_target_decode.sv
/* APB address decoder: region N+1 selects register block N, the next region
   is an absent target and every other region answers with a slave error. */

`timescale 1ns/10ps

module apb_target_decode (
  input  logic                                        psel,
  input  logic [31:0]                                 paddr,
  output logic [cfg_apb_pkg::NUM_TARGETS-1:0]         sel,
  input  logic [cfg_apb_pkg::NUM_TARGETS-1:0]         t_pready,
  input  logic [cfg_apb_pkg::NUM_TARGETS-1:0]         t_pslverr,
  input  logic [cfg_apb_pkg::NUM_TARGETS-1:0]         t_prdata_par,
  input  logic [cfg_apb_pkg::NUM_TARGETS-1:0][31:0]   t_prdata,
  output logic                                        pready,
  output logic                                        pslverr,
  output logic [31:0]                                 prdata,
  output logic                                        prdata_par
);

  // Region just past the populated blocks, nothing there ever answers
  localparam logic [3:0] ABSENT_REGION = 4'(cfg_apb_pkg::NUM_TARGETS + 1);

  logic [3:0] region;

  assign region = paddr[31:28];

  // Block i lives at region i+1
  always_comb begin
    for (int i = 0; i < cfg_apb_pkg::NUM_TARGETS; i++) begin
      sel[i] = psel && (region == 4'(i + 1));
    end
  end

  // --------------------
  // Response mux

  always_comb begin
    // Error regions, zero data with its even parity
    pready     = 1'b1;
    pslverr    = 1'b1;
    prdata     = '0;
    prdata_par = 1'b0;
    if (region == ABSENT_REGION) begin
      pready  = 1'b0;
      pslverr = 1'b0;
    end
    for (int i = 0; i < cfg_apb_pkg::NUM_TARGETS; i++) begin
      if (region == 4'(i + 1)) begin
        pready     = t_pready[i];
        pslverr    = t_pslverr[i];
        prdata     = t_prdata[i];
        prdata_par = t_prdata_par[i];
      end
    end
  end

endmodule

//--- cfg_apb.f
cfg_apb_pkg.sv
cfg_apb_master.sv
apb_target_decode.sv
apb_csr_block.sv
cfg_apb_top.sv
cfg_apb_properties.sv
cfg_apb_tb.sv

//--- cfg_apb_master.sv
/* Bridge master: checks cfg requests, rejects bad ones with a miss and turns
   the rest into single APB transfers with a programmable timeout. */

`timescale 1ns/10ps

module cfg_apb_master (
  input  logic                        prim_gated_clk,
  input  logic                        prim_gated_rst_b,
  input  logic                        func_rst_b,
  input  cfg_apb_pkg::cfg_req_t       cfg_req,
  input  logic                        apar,
  input  logic                        dpar,
  input  cfg_apb_pkg::access_policy_t policy,
  input  cfg_apb_pkg::timeout_cfg_t   timeout_cfg,
  output cfg_apb_pkg::cfg_ack_t       cfg_ack,
  output logic [1:0]                  ack_err,
  output logic                        timeout_error,
  output logic                        idle,
  output logic                        psel,
  output logic                        penable,
  output logic                        pwrite,
  output logic [31:0]                 paddr,
  output logic [31:0]                 pwdata,
  output cfg_apb_pkg::apb_user_t      puser,
  input  logic                        pready,
  input  logic                        pslverr,
  input  logic [31:0]                 prdata,
  input  logic                        prdata_par
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_DONE
  } state_e;

  state_e      state_q;
  state_e      state_next;

  logic        ack_pulse;
  logic        req_live;
  logic        is_read;
  logic        op_ok;
  logic        region_ok;
  logic        policy_ok;
  logic        accept;
  logic        start;
  logic        reject;
  logic        in_access;
  logic        in_done;
  logic        tout_hit;

  logic        pwrite_q;
  logic [31:0] paddr_q;
  logic [31:0] pwdata_q;
  logic        apar_q;
  logic        dpar_q;
  logic [31:0] tcnt_q;
  logic        timeout_q;

  logic        slverr_q;
  logic [31:0] rdata_q;
  logic        rpar_q;

  logic        rvalid_q;
  logic        wvalid_q;
  logic        miss_q;
  logic        priv_q;
  logic [31:0] ack_data_q;

  // --------------------
  // Request check

  // A request still held during its own acknowledge must not be taken twice
  assign ack_pulse = rvalid_q | wvalid_q;
  assign req_live  = cfg_req.valid & ~ack_pulse & (state_q == ST_IDLE);

  assign is_read = (cfg_req.opcode == cfg_apb_pkg::MRD) ||
                   (cfg_req.opcode == cfg_apb_pkg::CFGRD);
  assign op_ok   = (cfg_req.opcode == cfg_apb_pkg::MRD) ||
                   (cfg_req.opcode == cfg_apb_pkg::MWR);

  assign region_ok = (cfg_req.addr[31:28] >= 4'd1) && (cfg_req.addr[31:28] <= 4'd10);

  // BAR 0 bypasses the policy
  assign policy_ok = (cfg_req.bar == 3'd0) || (is_read ? policy.rd_en : policy.wr_en);

  assign accept = op_ok & (&cfg_req.be) & region_ok & policy_ok;
  assign start  = req_live & accept;
  assign reject = req_live & ~accept;

  assign in_access = (state_q == ST_ACCESS);
  assign in_done   = (state_q == ST_DONE);
  assign tout_hit  = timeout_cfg.enable & tcnt_q[timeout_cfg.pwr2];

  // --------------------
  // APB phase FSM

  always_comb begin
    state_next = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start) begin
          state_next = ST_SETUP;
        end
      end
      ST_SETUP: begin
        state_next = ST_ACCESS;
      end
      // pready wins over a timeout in the same cycle
      ST_ACCESS: begin
        if (pready || tout_hit) begin
          state_next = ST_DONE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge prim_gated_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      state_q   <= ST_IDLE;
      pwrite_q  <= 1'b0;
      tcnt_q    <= '0;
      timeout_q <= 1'b0;
      rvalid_q  <= 1'b0;
      wvalid_q  <= 1'b0;
      miss_q    <= 1'b0;
      priv_q    <= 1'b1;
    end else if (!func_rst_b) begin
      state_q   <= ST_IDLE;
      pwrite_q  <= 1'b0;
      tcnt_q    <= '0;
      timeout_q <= 1'b0;
      rvalid_q  <= 1'b0;
      wvalid_q  <= 1'b0;
      miss_q    <= 1'b0;
      priv_q    <= 1'b1;
    end else begin
      state_q <= state_next;
      if (start) begin
        pwrite_q <= ~is_read;
      end
      // Enable cycles of the current transfer
      if (in_access && !pready) begin
        tcnt_q <= tcnt_q + 32'd1;
      end else begin
        tcnt_q <= '0;
      end
      if (in_access && !pready && tout_hit) begin
        timeout_q <= 1'b1;
      end else if (in_done) begin
        timeout_q <= 1'b0;
      end
      rvalid_q <= (reject & is_read) | (in_done & ~pwrite_q);
      wvalid_q <= (reject & ~is_read) | (in_done & pwrite_q);
      miss_q   <= reject | (in_done & timeout_q);
      priv_q   <= policy_ok;
    end
  end

  // --------------------
  // Request and response payload

  always_ff @(posedge prim_gated_clk) begin
    if (start) begin
      paddr_q  <= cfg_req.addr;
      pwdata_q <= cfg_req.data;
      apar_q   <= apar;
      dpar_q   <= dpar;
    end
    if (in_access && pready) begin
      slverr_q <= pslverr;
      rdata_q  <= prdata;
      rpar_q   <= prdata_par;
    end
    // Misses, timeouts and writes return zero data
    if (reject || in_done) begin
      ack_data_q <= (in_done & ~timeout_q & ~pwrite_q) ? rdata_q : '0;
    end
  end

  assign psel         = (state_q == ST_SETUP) || in_access;
  assign penable      = in_access;
  assign pwrite       = pwrite_q;
  assign paddr        = paddr_q;
  assign pwdata       = pwdata_q;
  assign puser.a_par  = apar_q;
  assign puser.wd_par = dpar_q;

  // --------------------
  // Acknowledge

  assign cfg_ack.read_valid  = rvalid_q;
  assign cfg_ack.read_miss   = rvalid_q & miss_q;
  assign cfg_ack.write_valid = wvalid_q;
  assign cfg_ack.write_miss  = wvalid_q & miss_q;
  assign cfg_ack.priv_ok     = ~ack_pulse | priv_q;
  assign cfg_ack.data        = ack_data_q;

  // Bit 1 slave error, bit 0 read data parity mismatch
  assign ack_err = {ack_pulse & ~miss_q & slverr_q,
                    rvalid_q & ~miss_q & (^{rpar_q, rdata_q})};

  assign timeout_error = timeout_q;
  assign idle          = (state_q == ST_IDLE);

endmodule

//--- cfg_apb_pkg.sv
/* Shared types for the configuration-space bridge.
   Compiled first; every other file refers to these by scoped name. */

package cfg_apb_pkg;

  // --------------------
  // Request side

  // Only MRD and MWR are ever turned into APB transfers
  typedef enum logic [1:0] {
    MRD   = 2'd0,
    MWR   = 2'd1,
    CFGRD = 2'd2,
    IOWR  = 2'd3
  } cfg_op_e;

  typedef struct packed {
    logic        valid;
    cfg_op_e     opcode;
    logic [2:0]  bar;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] data;
  } cfg_req_t;

  typedef struct packed {
    logic        read_valid;
    logic        read_miss;
    logic        write_valid;
    logic        write_miss;
    logic        priv_ok;
    logic [31:0] data;
  } cfg_ack_t;

  // Applies to every BAR except BAR 0, which is always open
  typedef struct packed {
    logic rd_en;
    logic wr_en;
  } access_policy_t;

  // Timeout fires once bit pwr2 of the enable-cycle counter is set
  typedef struct packed {
    logic       enable;
    logic [4:0] pwr2;
  } timeout_cfg_t;

  // --------------------
  // APB side

  // Even parity over paddr and pwdata
  typedef struct packed {
    logic a_par;
    logic wd_par;
  } apb_user_t;

  // Populated register blocks behind the decoder
  localparam int NUM_TARGETS = 2;

endpackage

//--- cfg_apb_properties.sv
/* Protocol assertions for the bridge master, attached to it with bind.
   Covers the APB phase rules and the shape of the acknowledge pulse. */

`timescale 1ns/10ps

module cfg_apb_properties (
  input logic                  prim_gated_clk,
  input logic                  prim_gated_rst_b,
  input logic                  psel,
  input logic                  penable,
  input logic [31:0]           paddr,
  input cfg_apb_pkg::cfg_ack_t cfg_ack
);

  logic ack_pulse;

  assign ack_pulse = cfg_ack.read_valid | cfg_ack.write_valid;

  // --------------------
  // APB phases

  // Access phase only ever follows a setup cycle with psel already high
  enable_needs_select: assert property (@(posedge prim_gated_clk) disable iff (!prim_gated_rst_b)
    penable |-> (psel && $past(psel)))
    else $error("penable high without psel or without a setup phase before it");

  addr_stable_in_transfer: assert property (@(posedge prim_gated_clk)
    disable iff (!prim_gated_rst_b)
    psel |=> (!psel || $stable(paddr)))
    else $error("paddr changed while psel was held");

  // --------------------
  // Acknowledge

  single_ack_kind: assert property (@(posedge prim_gated_clk) disable iff (!prim_gated_rst_b)
    !(cfg_ack.read_valid && cfg_ack.write_valid))
    else $error("read_valid and write_valid high together");

  idle_after_ack: assert property (@(posedge prim_gated_clk) disable iff (!prim_gated_rst_b)
    ack_pulse |=> !psel)
    else $error("psel high in the cycle after an acknowledge");

endmodule

bind cfg_apb_master cfg_apb_properties cfg_apb_properties_inst (
  .prim_gated_clk   (prim_gated_clk),
  .prim_gated_rst_b (prim_gated_rst_b),
  .psel             (psel),
  .penable          (penable),
  .paddr            (paddr),
  .cfg_ack          (cfg_ack)
);

//--- cfg_apb_tb.sv
/* Testbench for the bridge: random requests from a fixed seed, checked
   against a word and parity model of both register blocks. */

`timescale 1ns/10ps

module cfg_apb_tb;

  localparam int REGS    = 16;
  localparam int ACK_MAX = 200;

  logic                        prim_gated_clk;
  logic                        prim_gated_rst_b;
  logic                        func_rst_b;
  cfg_apb_pkg::cfg_req_t       cfg_req;
  logic                        apar;
  logic                        dpar;
  cfg_apb_pkg::access_policy_t policy;
  cfg_apb_pkg::timeout_cfg_t   timeout_cfg;
  cfg_apb_pkg::cfg_ack_t       cfg_ack;
  logic [1:0]                  ack_err;
  logic                        timeout_error;
  logic                        idle;

  integer      seed;
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          test_err;
  logic [31:0] model_word [2][REGS];
  logic        model_par  [2][REGS];
  logic [31:0] addr_log   [24];

  // What the last wait for an acknowledge saw
  bit          ack_got;
  int          ack_cycles;
  bit          tout_seen;
  bit          psel_seen;

  cfg_apb_top #(
    .REGS_PER_BLOCK (REGS),
    .WAIT_STATES_0  (0),
    .WAIT_STATES_1  (2)
  ) cfg_apb_top_inst (
    .prim_gated_clk   (prim_gated_clk),
    .prim_gated_rst_b (prim_gated_rst_b),
    .func_rst_b       (func_rst_b),
    .cfg_req          (cfg_req),
    .apar             (apar),
    .dpar             (dpar),
    .policy           (policy),
    .timeout_cfg      (timeout_cfg),
    .cfg_ack          (cfg_ack),
    .ack_err          (ack_err),
    .timeout_error    (timeout_error),
    .idle             (idle)
  );

  always #2 prim_gated_clk = ~prim_gated_clk;

  // --------------------
  // Checks and bookkeeping

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_val(name, 32'(got), 32'(exp));
  endtask

  task automatic check_true(input bit cond, input string what);
    check_cnt++;
    assert (cond) else begin
      $display("at %0t ns: %s", $time, what);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (test_err == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_err);
    end
    test_err = 0;
  endtask

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  function automatic logic [31:0] make_addr(input logic [3:0] region, input logic [25:0] word);
    return {region, word, 2'b00};
  endfunction

  // --------------------
  // Request driving

  task automatic drive_req(input cfg_apb_pkg::cfg_op_e op, input logic [2:0] bar,
                           input logic [3:0] be, input logic [31:0] addr,
                           input logic [31:0] data, input bit bad_par);
    cfg_req.valid  = 1'b1;
    cfg_req.opcode = op;
    cfg_req.bar    = bar;
    cfg_req.be     = be;
    cfg_req.addr   = addr;
    cfg_req.data   = data;
    apar           = ^addr;
    dpar           = (^data) ^ bad_par;
  endtask

  // Sampled 1 ns after each edge, where every DUT output is settled
  task automatic wait_ack(input int limit);
    ack_got    = 0;
    ack_cycles = 0;
    tout_seen  = 0;
    psel_seen  = 0;
    while (!ack_got && ack_cycles < limit) begin
      @(posedge prim_gated_clk);
      #1;
      ack_cycles++;
      if (timeout_error) tout_seen = 1;
      if (cfg_apb_top_inst.psel) psel_seen = 1;
      if (cfg_ack.read_valid || cfg_ack.write_valid) ack_got = 1;
    end
  endtask

  task automatic pulse_func_rst();
    cfg_req.valid = 1'b0;
    func_rst_b    = 1'b0;
    @(posedge prim_gated_clk);
    #1;
    func_rst_b = 1'b1;
    check_bit("idle", idle, 1'b1);
    check_bit("timeout_error", timeout_error, 1'b0);
    check_bit("cfg_ack.read_valid", cfg_ack.read_valid, 1'b0);
    check_bit("cfg_ack.write_valid", cfg_ack.write_valid, 1'b0);
  endtask

  // One full request with the expected acknowledge worked out from the rules
  task automatic do_req(input cfg_apb_pkg::cfg_op_e op, input logic [2:0] bar,
                        input logic [3:0] be, input logic [31:0] addr,
                        input logic [31:0] data, input bit bad_par);
    bit          is_read;
    bit          exp_priv;
    bit          accept;
    bit          exp_miss;
    logic [1:0]  exp_err;
    logic [31:0] exp_data;
    logic [3:0]  region;
    int          blk;
    int          word;
    region   = addr[31:28];
    word     = int'(addr[27:2]);
    is_read  = (op == cfg_apb_pkg::MRD) || (op == cfg_apb_pkg::CFGRD);
    exp_priv = (bar == 3'd0) || (is_read ? policy.rd_en : policy.wr_en);
    accept   = ((op == cfg_apb_pkg::MRD) || (op == cfg_apb_pkg::MWR)) && (be == 4'hf) &&
               (region >= 4'd1) && (region <= 4'd10) && exp_priv;
    exp_miss = !accept || (region == 4'd3);
    exp_err  = 2'b00;
    exp_data = '0;
    if (accept && region >= 4'd4) exp_err = 2'b10;
    if (accept && (region == 4'd1 || region == 4'd2)) begin
      blk = int'(region) - 1;
      if (word >= REGS) begin
        exp_err = 2'b10;
      end else if (is_read) begin
        exp_data   = model_word[blk][word];
        exp_err[0] = model_par[blk][word] ^ (^model_word[blk][word]);
      end else begin
        model_word[blk][word] = data;
        model_par[blk][word]  = (^data) ^ bad_par;
      end
    end

    drive_req(op, bar, be, addr, data, bad_par);
    wait_ack(ACK_MAX);
    cfg_req.valid = 1'b0;
    check_true(ack_got, $sformatf("no acknowledge for a request to %h", addr));
    if (ack_got) begin
      check_bit("cfg_ack.read_valid", cfg_ack.read_valid, is_read);
      check_bit("cfg_ack.write_valid", cfg_ack.write_valid, !is_read);
      check_bit("cfg_ack.read_miss", cfg_ack.read_miss, is_read && exp_miss);
      check_bit("cfg_ack.write_miss", cfg_ack.write_miss, !is_read && exp_miss);
      check_bit("cfg_ack.priv_ok", cfg_ack.priv_ok, exp_priv);
      check_val("ack_err", 32'(ack_err), 32'(exp_err));
      if (is_read && accept) check_val("cfg_ack.data", cfg_ack.data, exp_data);
      if (!accept) begin
        check_val("reject latency", 32'(ack_cycles), 32'd1);
        check_true(!psel_seen, "rejected request reached the APB bus");
      end
      if (accept && region == 4'd3) begin
        check_true(tout_seen, "timeout_error never went high before the timeout miss");
      end
    end
    // Requester stays quiet for the acknowledge cycle
    @(posedge prim_gated_clk);
    #1;
  endtask

  task automatic read_all();
    for (int b = 0; b < 2; b++) begin
      for (int w = 0; w < REGS; w++) begin
        do_req(cfg_apb_pkg::MRD, 3'd0, 4'hf, make_addr(b ? 4'd2 : 4'd1, 26'(w)), '0, 1'b0);
      end
    end
  endtask

  // --------------------
  // Tests

  task automatic run_write_read();
    logic [31:0] r;
    for (int i = 0; i < 24; i++) begin
      r = next_rand();
      addr_log[i] = make_addr(r[0] ? 4'd2 : 4'd1, 26'(r[4:1]));
      do_req(cfg_apb_pkg::MWR, r[7:5], 4'hf, addr_log[i], next_rand(), 1'b0);
    end
    for (int i = 0; i < 24; i++) begin
      r = next_rand();
      do_req(cfg_apb_pkg::MRD, r[7:5], 4'hf, addr_log[i], '0, 1'b0);
    end
    finish_test("write then read");
  endtask

  task automatic run_rejects();
    logic [31:0]          r;
    cfg_apb_pkg::cfg_op_e op;
    logic [2:0]           bar;
    logic [3:0]           be;
    logic [3:0]           region;
    for (int i = 0; i < 16; i++) begin
      r      = next_rand();
      op     = r[8] ? cfg_apb_pkg::MWR : cfg_apb_pkg::MRD;
      bar    = r[11:9];
      be     = 4'hf;
      region = r[0] ? 4'd2 : 4'd1;
      case (i % 4)
        0: op = r[12] ? cfg_apb_pkg::IOWR : cfg_apb_pkg::CFGRD;
        1: be = (r[19:16] == 4'hf) ? 4'h7 : r[19:16];
        2: region = (r[15:13] < 3'd5) ? (4'd11 + {1'b0, r[15:13]}) : 4'd0;
        default: begin
          bar    = {r[11:10], 1'b1};
          policy = '{rd_en: 1'b0, wr_en: 1'b0};
        end
      endcase
      do_req(op, bar, be, make_addr(region, 26'(r[4:1])), next_rand(), 1'b0);
      policy = '{rd_en: 1'b1, wr_en: 1'b1};
    end
    // Nothing above may have touched the blocks
    read_all();
    finish_test("rejected requests");
  endtask

  task automatic run_slave_errors();
    logic [31:0] r;
    for (int i = 0; i < 12; i++) begin
      r = next_rand();
      if (i % 2 == 0) begin
        do_req(r[8] ? cfg_apb_pkg::MWR : cfg_apb_pkg::MRD, 3'd0, 4'hf,
               make_addr(4'(4 + int'(r[7:0]) % 7), 26'(r[19:12])), next_rand(), 1'b0);
      end else begin
        do_req(r[8] ? cfg_apb_pkg::MWR : cfg_apb_pkg::MRD, 3'd0, 4'hf,
               make_addr(r[0] ? 4'd2 : 4'd1, 26'(16 + int'(r[25:16]))), next_rand(), 1'b0);
      end
    end
    read_all();
    finish_test("slave errors");
  endtask

  task automatic run_parity();
    logic [31:0] addr;
    logic [31:0] r;
    for (int b = 0; b < 2; b++) begin
      r    = next_rand();
      addr = make_addr(b ? 4'd2 : 4'd1, 26'(r[3:0]));
      do_req(cfg_apb_pkg::MWR, 3'd0, 4'hf, addr, next_rand(), 1'b1);
      do_req(cfg_apb_pkg::MRD, 3'd0, 4'hf, addr, '0, 1'b0);
      do_req(cfg_apb_pkg::MWR, 3'd0, 4'hf, addr, next_rand(), 1'b0);
      do_req(cfg_apb_pkg::MRD, 3'd0, 4'hf, addr, '0, 1'b0);
    end
    finish_test("read parity");
  endtask

  task automatic run_timeout();
    timeout_cfg = '{enable: 1'b1, pwr2: 5'd3};
    do_req(cfg_apb_pkg::MRD, 3'd0, 4'hf, make_addr(4'd3, 26'd5), '0, 1'b0);
    do_req(cfg_apb_pkg::MWR, 3'd0, 4'hf, make_addr(4'd3, 26'd1), next_rand(), 1'b0);
    // Without the timeout the absent target holds the bus until reset
    timeout_cfg.enable = 1'b0;
    drive_req(cfg_apb_pkg::MRD, 3'd0, 4'hf, make_addr(4'd3, 26'd0), '0, 1'b0);
    wait_ack(64);
    check_true(!ack_got, "acknowledge from the absent target with the timeout disabled");
    pulse_func_rst();
    timeout_cfg = '{enable: 1'b1, pwr2: 5'd4};
    read_all();
    finish_test("timeout");
  endtask

  task automatic run_func_reset();
    logic [31:0] addr;
    logic [31:0] r;
    r    = next_rand();
    addr = make_addr(4'd2, 26'(r[3:0]));
    drive_req(cfg_apb_pkg::MRD, 3'd0, 4'hf, addr, '0, 1'b0);
    wait_ack(2);
    check_true(psel_seen, "block 2 access never reached the APB bus before func_rst_b");
    check_true(!ack_got, "acknowledge before the block 2 wait states ran out");
    pulse_func_rst();
    wait_ack(10);
    check_true(!ack_got, "acknowledge still pending after func_rst_b");
    do_req(cfg_apb_pkg::MRD, 3'd0, 4'hf, addr, '0, 1'b0);
    do_req(cfg_apb_pkg::MWR, 3'd0, 4'hf, addr, next_rand(), 1'b0);
    do_req(cfg_apb_pkg::MRD, 3'd0, 4'hf, addr, '0, 1'b0);
    finish_test("function reset");
  endtask

  initial begin
    seed             = 53253;
    err_cnt          = 0;
    check_cnt        = 0;
    test_cnt         = 0;
    test_err         = 0;
    prim_gated_clk   = 1'b0;
    prim_gated_rst_b = 1'b0;
    func_rst_b       = 1'b1;
    cfg_req          = '0;
    apar             = 1'b0;
    dpar             = 1'b0;
    policy           = '{rd_en: 1'b1, wr_en: 1'b1};
    timeout_cfg      = '{enable: 1'b1, pwr2: 5'd4};
    for (int b = 0; b < 2; b++) begin
      for (int w = 0; w < REGS; w++) begin
        model_word[b][w] = '0;
        model_par[b][w]  = 1'b0;
      end
    end
    repeat (4) @(posedge prim_gated_clk);
    #1;
    prim_gated_rst_b = 1'b1;

    run_write_read();
    run_rejects();
    run_slave_errors();
    run_parity();
    run_timeout();
    run_func_reset();

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- cfg_apb_top.sv
/* Bridge top: master, address decoder and two register blocks.
   Only the cfg side is exposed; the APB bus stays internal. */

`timescale 1ns/10ps

module cfg_apb_top #(
  parameter int REGS_PER_BLOCK = 16,
  parameter int WAIT_STATES_0  = 0,
  parameter int WAIT_STATES_1  = 2
) (
  input  logic                        prim_gated_clk,
  input  logic                        prim_gated_rst_b,
  input  logic                        func_rst_b,
  input  cfg_apb_pkg::cfg_req_t       cfg_req,
  input  logic                        apar,
  input  logic                        dpar,
  input  cfg_apb_pkg::access_policy_t policy,
  input  cfg_apb_pkg::timeout_cfg_t   timeout_cfg,
  output cfg_apb_pkg::cfg_ack_t       cfg_ack,
  output logic [1:0]                  ack_err,
  output logic                        timeout_error,
  output logic                        idle
);

  // --------------------
  // Master side APB
  logic                                      psel;
  logic                                      penable;
  logic                                      pwrite;
  logic [31:0]                               paddr;
  logic [31:0]                               pwdata;
  cfg_apb_pkg::apb_user_t                    puser;
  logic                                      pready;
  logic                                      pslverr;
  logic [31:0]                               prdata;
  logic                                      prdata_par;

  // Per block select and response
  logic [cfg_apb_pkg::NUM_TARGETS-1:0]       sel;
  logic [cfg_apb_pkg::NUM_TARGETS-1:0]       t_pready;
  logic [cfg_apb_pkg::NUM_TARGETS-1:0]       t_pslverr;
  logic [cfg_apb_pkg::NUM_TARGETS-1:0]       t_prdata_par;
  logic [cfg_apb_pkg::NUM_TARGETS-1:0][31:0] t_prdata;

  cfg_apb_master cfg_apb_master_inst (
    .prim_gated_clk   (prim_gated_clk),
    .prim_gated_rst_b (prim_gated_rst_b),
    .func_rst_b       (func_rst_b),
    .cfg_req          (cfg_req),
    .apar             (apar),
    .dpar             (dpar),
    .policy           (policy),
    .timeout_cfg      (timeout_cfg),
    .cfg_ack          (cfg_ack),
    .ack_err          (ack_err),
    .timeout_error    (timeout_error),
    .idle             (idle),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .puser            (puser),
    .pready           (pready),
    .pslverr          (pslverr),
    .prdata           (prdata),
    .prdata_par       (prdata_par)
  );

  apb_target_decode apb_target_decode_inst (
    .psel         (psel),
    .paddr        (paddr),
    .sel          (sel),
    .t_pready     (t_pready),
    .t_pslverr    (t_pslverr),
    .t_prdata_par (t_prdata_par),
    .t_prdata     (t_prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .prdata       (prdata),
    .prdata_par   (prdata_par)
  );

  // Block 0 at region 1
  apb_csr_block #(
    .REGS_PER_BLOCK (REGS_PER_BLOCK),
    .WAIT_STATES    (WAIT_STATES_0)
  ) apb_csr_block_0 (
    .prim_gated_clk   (prim_gated_clk),
    .prim_gated_rst_b (prim_gated_rst_b),
    .sel              (sel[0]),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .puser            (puser),
    .pready           (t_pready[0]),
    .pslverr          (t_pslverr[0]),
    .prdata           (t_prdata[0]),
    .prdata_par       (t_prdata_par[0])
  );

  // Block 1 at region 2
  apb_csr_block #(
    .REGS_PER_BLOCK (REGS_PER_BLOCK),
    .WAIT_STATES    (WAIT_STATES_1)
  ) apb_csr_block_1 (
    .prim_gated_clk   (prim_gated_clk),
    .prim_gated_rst_b (prim_gated_rst_b),
    .sel              (sel[1]),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .puser            (puser),
    .pready           (t_pready[1]),
    .pslverr          (t_pslverr[1]),
    .prdata           (t_prdata[1]),
    .prdata_par       (t_prdata_par[1])
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator, runs it and checks the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f cfg_apb.f --top-module cfg_apb_tb

out=$(./obj_dir/Vcfg_apb_tb || true)
echo "$out"

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
